/* compile.f */
cpu_ctrl_pkg.sv
instr_decode.sv
seq_fsm.sv
ctrl_assemble.sv
seq_ctrl_top.sv
tb_seq_ctrl.sv

/* cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // ------------------------------
    // Instruction set
    // ------------------------------

    // Opcode field, codes 14 and 15 unused
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,      // No operation
        OP_HLT = 4'd1,      // Stop, idle until reset
        OP_LDI = 4'd2,      // Load immediate into dest reg
        OP_LD  = 4'd3,      // Load from direct address
        OP_ST  = 4'd4,      // Store to direct address
        OP_OUT = 4'd5,      // Copy reg or memory to output register
        OP_STX = 4'd6,      // Store, address from src2
        OP_JMP = 4'd7,      // Jump to reg value
        OP_BRD = 4'd8,      // Conditional direct branch
        OP_ADD = 4'd9,
        OP_SUB = 4'd10,     // With ignore_dest this is a compare
        OP_AND = 4'd11,
        OP_OR  = 4'd12,
        OP_XOR = 4'd13
    } opcode_t;

    // Instruction register layout
    // Low 9 bits double as immediate or address, sliced by the datapath
    typedef struct packed {
        opcode_t    opcode;         // [15:12]
        logic [2:0] dest_or_cond;   // [11:9] dest reg, OUT source or branch cond
        logic       ignore_dest;    // [8] ALU result dropped, flags only
        logic       rsvd_7;         // [7]
        logic [2:0] src2;           // [6:4]
        logic       rsvd_3;         // [3]
        logic [2:0] src1;           // [2:0]
    } instr_t;

    // Bit of dest_or_cond selecting the OUT source
    localparam int OUT_SRC_BIT = 2;     // 1 = register file

    // Branch condition, top two bits of dest_or_cond
    typedef enum logic [1:0] {
        COND_EQ = 2'b00,    // Z set
        COND_NE = 2'b01,    // Z clear
        COND_LT = 2'b10,    // N != V, signed less
        COND_CS = 2'b11     // Carry set
    } branch_cond_t;

    // ALU status flags
    typedef struct packed {
        logic v;    // Overflow
        logic n;    // Negative
        logic c;    // Carry out
        logic z;    // Zero result
    } flags_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4
    } alu_op_t;

    // ------------------------------
    // Sequencer
    // ------------------------------
    typedef enum logic [2:0] {
        PH_IDLE       = 3'd0,   // Halted
        PH_RESET      = 3'd1,
        PH_FETCH_ADDR = 3'd2,   // PC onto memory address
        PH_FETCH_LOAD = 3'd3,   // Memory into IR, bump PC
        PH_DECODE     = 3'd4,
        PH_EXECUTE    = 3'd5    // Optional second cycle
    } phase_t;

    // ------------------------------
    // Datapath selects
    // ------------------------------
    typedef enum logic [1:0] {
        PC_BRANCH = 2'b00,      // Branch target from IR
        PC_REG    = 2'b10       // Reg file src1
    } pc_src_t;

    typedef enum logic [1:0] {
        ADDR_PC   = 2'b00,
        ADDR_REG2 = 2'b01,      // Reg file src2
        ADDR_IMM  = 2'b10       // Zero extended IR field
    } addr_src_t;

    typedef enum logic [1:0] {
        DATA_IMM = 2'b00,
        DATA_MEM = 2'b01,
        DATA_ALU = 2'b10
    } data_src_t;

    typedef enum logic [1:0] {
        OUT_MEM = 2'b00,
        OUT_REG = 2'b01
    } out_sel_t;

    typedef enum logic {
        SRC1_A    = 1'b0,       // Read port 1 from src1 field
        SRC1_DEST = 1'b1        // Read port 1 from dest field, ST data
    } src1_sel_t;

    // Control word to the datapath, all strobes active high
    typedef struct packed {
        logic      pc_rst;
        logic      pc_inc;
        logic      pc_ld;
        logic      ir_ld;
        logic      mem_en;
        logic      mem_wr;
        logic      reg_we;
        logic      alu_ld;
        logic      flg_ld;
        logic      flg_rst;
        logic      out_ld;
        pc_src_t   pc_src;
        addr_src_t addr_src;
        data_src_t data_src;
        src1_sel_t src1_sel;
        out_sel_t  out_sel;
        alu_op_t   alu_op;
    } ctrl_t;

    localparam ctrl_t CTRL_NONE = '0;   // Every strobe low

    // Decoder summary of the IR
    typedef struct packed {
        opcode_t op;            // Unused codes folded to NOP
        logic    is_alu;
        alu_op_t alu_op;
        logic    needs_execute; // Extra cycle after decode
        logic    out_from_reg;
        logic    branch_taken;  // BRD only
    } decode_t;

endpackage

/* ctrl_assemble.sv */
`timescale 1ns/100ps

module ctrl_assemble (
    input  logic                  Clk,
    input  cpu_ctrl_pkg::phase_t  phase,
    input  cpu_ctrl_pkg::decode_t dec,
    output cpu_ctrl_pkg::ctrl_t   ctrl
);
    import cpu_ctrl_pkg::*;

    // ------------------------------
    // Control word per phase
    // ------------------------------
    always_comb begin
        ctrl = CTRL_NONE;   // Anything not set stays low

        case (phase)
            PH_RESET: begin
                ctrl.pc_rst = 1'b1;
            end

            // Fetch, part 1
            PH_FETCH_ADDR: begin
                ctrl.mem_en   = 1'b1;           // Memory read
                ctrl.addr_src = ADDR_PC;
            end

            // Fetch, part 2
            PH_FETCH_LOAD: begin
                ctrl.ir_ld  = 1'b1;
                ctrl.pc_inc = 1'b1;             // Bump PC on the same edge
            end

            PH_DECODE: begin
                case (dec.op)
                    OP_LDI: begin
                        ctrl.reg_we   = 1'b1;
                        ctrl.data_src = DATA_IMM;
                    end
                    OP_LD: begin
                        // Address now, data in execute
                        ctrl.mem_en   = 1'b1;
                        ctrl.addr_src = ADDR_IMM;
                    end
                    OP_ST: begin
                        ctrl.mem_en   = 1'b1;
                        ctrl.mem_wr   = 1'b1;
                        ctrl.addr_src = ADDR_IMM;
                        ctrl.src1_sel = SRC1_DEST;  // Store data from dest field
                    end
                    OP_STX: begin
                        ctrl.mem_en   = 1'b1;
                        ctrl.mem_wr   = 1'b1;
                        ctrl.addr_src = ADDR_REG2;  // Data on src1, address on src2
                    end
                    OP_OUT: begin
                        if (dec.out_from_reg) begin
                            ctrl.out_ld  = 1'b1;
                            ctrl.out_sel = OUT_REG;
                        end else begin
                            ctrl.mem_en   = 1'b1;   // Read now, load in execute
                            ctrl.addr_src = ADDR_IMM;
                            ctrl.out_sel  = OUT_MEM;
                        end
                    end
                    OP_JMP: begin
                        ctrl.pc_ld  = 1'b1;
                        ctrl.pc_src = PC_REG;
                    end
                    OP_BRD: begin
                        ctrl.flg_rst = 1'b1;        // Flags cleared either way
                        if (dec.branch_taken) begin
                            ctrl.pc_ld  = 1'b1;
                            ctrl.pc_src = PC_BRANCH;
                        end
                    end
                    default: begin
                        // ALU group, NOP and HLT drive nothing
                        if (dec.is_alu) begin
                            ctrl.alu_op = dec.alu_op;
                            ctrl.flg_ld = 1'b1;     // Flags always updated
                            // Result latched only when kept
                            ctrl.alu_ld = dec.needs_execute;
                        end
                    end
                endcase
            end

            PH_EXECUTE: begin
                case (dec.op)
                    OP_LD: begin
                        ctrl.reg_we   = 1'b1;
                        ctrl.data_src = DATA_MEM;
                    end
                    OP_OUT: begin
                        if (!dec.out_from_reg) begin
                            ctrl.out_ld  = 1'b1;
                            ctrl.out_sel = OUT_MEM;
                        end
                    end
                    default: begin
                        if (dec.is_alu) begin
                            ctrl.reg_we   = 1'b1;   // ALU write back
                            ctrl.data_src = DATA_ALU;
                            ctrl.alu_op   = dec.alu_op;
                        end
                    end
                endcase
            end

            default: begin
                ctrl = CTRL_NONE;               // PH_IDLE, all quiet
            end
        endcase
    end

    // ------------------------------
    // Strobe combinations
    // ------------------------------
    a_wr_with_en : assert property (@(posedge Clk) ctrl.mem_wr |-> ctrl.mem_en)
        else $error("mem_wr without mem_en in phase %0d", phase);

    // Reg file and memory never written in one cycle
    a_wr_exclusive : assert property (@(posedge Clk) !(ctrl.reg_we && ctrl.mem_wr))
        else $error("reg_we and mem_wr together in phase %0d", phase);

    a_pc_exclusive : assert property (@(posedge Clk) !(ctrl.pc_ld && ctrl.pc_inc))
        else $error("pc_ld and pc_inc together in phase %0d", phase);

endmodule

/* instr_decode.sv */
`timescale 1ns/100ps

module instr_decode (
    input  cpu_ctrl_pkg::instr_t  ir,
    input  cpu_ctrl_pkg::flags_t  flags,
    output cpu_ctrl_pkg::decode_t dec
);
    import cpu_ctrl_pkg::*;

    opcode_t      op_norm;      // Opcode with unused codes as NOP
    branch_cond_t cond;         // BRD condition field
    logic         cond_met;     // Condition true on current flags
    logic         out_src_reg;  // OUT reads register file

    assign cond        = branch_cond_t'(ir.dest_or_cond[2:1]);
    assign out_src_reg = ir.dest_or_cond[OUT_SRC_BIT];

    // ------------------------------
    // Opcode cleanup
    // ------------------------------
    always_comb begin
        if (ir.opcode > OP_XOR) begin
            op_norm = OP_NOP;       // Codes 14, 15
        end else begin
            op_norm = ir.opcode;
        end
    end

    // ------------------------------
    // Branch condition
    // ------------------------------
    // Flags sampled while in decode
    always_comb begin
        case (cond)
            COND_EQ: cond_met = flags.z;
            COND_NE: cond_met = ~flags.z;
            COND_LT: cond_met = flags.n ^ flags.v;  // Sign differs from overflow
            default: cond_met = flags.c;            // COND_CS
        endcase
    end

    // ------------------------------
    // Instruction class
    // ------------------------------
    always_comb begin
        dec        = '0;
        dec.op     = op_norm;
        dec.alu_op = ALU_ADD;

        case (op_norm)
            OP_LD: begin
                dec.needs_execute = 1'b1;   // Memory data written back next cycle
            end
            OP_OUT: begin
                dec.out_from_reg  = out_src_reg;
                // Memory read needs the extra cycle
                dec.needs_execute = ~out_src_reg;
            end
            OP_BRD: begin
                dec.branch_taken = cond_met;
            end
            OP_ADD: begin
                dec.is_alu = 1'b1;
                dec.alu_op = ALU_ADD;
            end
            OP_SUB: begin
                dec.is_alu = 1'b1;
                dec.alu_op = ALU_SUB;       // CMP when dest ignored
            end
            OP_AND: begin
                dec.is_alu = 1'b1;
                dec.alu_op = ALU_AND;
            end
            OP_OR: begin
                dec.is_alu = 1'b1;
                dec.alu_op = ALU_OR;
            end
            OP_XOR: begin
                dec.is_alu = 1'b1;
                dec.alu_op = ALU_XOR;
            end
            default: begin
                // NOP, HLT, LDI, ST, STX, JMP finish in decode
                dec.needs_execute = 1'b0;
            end
        endcase

        // Result kept, write back in execute
        if (dec.is_alu && !ir.ignore_dest) begin
            dec.needs_execute = 1'b1;
        end
    end

endmodule

/* seq_ctrl_top.sv */
`timescale 1ns/100ps

module seq_ctrl_top (
    input  logic                 Clk,
    input  logic                 rst,       // Synchronous, active high
    input  cpu_ctrl_pkg::instr_t ir,        // External IR
    input  cpu_ctrl_pkg::flags_t flags,     // ALU status
    output cpu_ctrl_pkg::ctrl_t  ctrl,      // To datapath
    output logic                 halted
);
    import cpu_ctrl_pkg::*;

    decode_t dec;       // Decoded IR
    phase_t  phase;     // Current sequencer phase

    // IR and flags to decode summary
    instr_decode u_decode (
        .ir    (ir),
        .flags (flags),
        .dec   (dec)
    );

    seq_fsm u_fsm (
        .Clk    (Clk),
        .rst    (rst),
        .dec    (dec),
        .phase  (phase),
        .halted (halted)
    );

    // Phase plus decode to control word
    ctrl_assemble u_assemble (
        .Clk   (Clk),
        .phase (phase),
        .dec   (dec),
        .ctrl  (ctrl)
    );

endmodule

/* seq_fsm.sv */
`timescale 1ns/100ps

module seq_fsm (
    input  logic                  Clk,
    input  logic                  rst,
    input  cpu_ctrl_pkg::decode_t dec,
    output cpu_ctrl_pkg::phase_t  phase,
    output logic                  halted
);
    import cpu_ctrl_pkg::*;

    phase_t next_phase;

    // ------------------------------
    // Next phase
    // ------------------------------
    always_comb begin
        case (phase)
            PH_IDLE:       next_phase = PH_IDLE;        // Only rst leaves
            PH_RESET:      next_phase = PH_FETCH_ADDR;
            PH_FETCH_ADDR: next_phase = PH_FETCH_LOAD;
            PH_FETCH_LOAD: next_phase = PH_DECODE;      // IR valid from here
            PH_DECODE: begin
                if (dec.op == OP_HLT) begin
                    next_phase = PH_IDLE;
                end else if (dec.needs_execute) begin
                    next_phase = PH_EXECUTE;
                end else begin
                    next_phase = PH_FETCH_ADDR;
                end
            end
            PH_EXECUTE:    next_phase = PH_FETCH_ADDR;
            default:       next_phase = PH_RESET;       // Illegal code, restart
        endcase
    end

    // Phase register
    always_ff @(posedge Clk) begin
        if (rst) begin
            phase <= PH_RESET;
        end else begin
            phase <= next_phase;
        end
    end

    assign halted = (phase == PH_IDLE);

    // ------------------------------
    // Checks
    // ------------------------------
    a_phase_legal : assert property (@(posedge Clk) disable iff (rst)
        phase inside {PH_IDLE, PH_RESET, PH_FETCH_ADDR, PH_FETCH_LOAD,
                      PH_DECODE, PH_EXECUTE})
        else $error("Illegal phase %0d", phase);

    // Fetch is never split
    a_fetch_pair : assert property (@(posedge Clk) disable iff (rst)
        phase == PH_FETCH_ADDR |=> phase == PH_FETCH_LOAD)
        else $error("PH_FETCH_ADDR not followed by PH_FETCH_LOAD");

endmodule

/* tb_seq_ctrl.sv */
`timescale 1ns/100ps

module tb_seq_ctrl;
    import cpu_ctrl_pkg::*;

    // About 190 instructions at up to 4 cycles, two resets, 20 idle cycles, then 3x margin
    localparam int MAX_CYCLES = 3000;

    // Strobe bits, same order as the control word
    localparam logic [10:0] S_PC_RST  = 11'b100_0000_0000;
    localparam logic [10:0] S_PC_INC  = 11'b010_0000_0000;
    localparam logic [10:0] S_PC_LD   = 11'b001_0000_0000;
    localparam logic [10:0] S_IR_LD   = 11'b000_1000_0000;
    localparam logic [10:0] S_MEM_EN  = 11'b000_0100_0000;
    localparam logic [10:0] S_MEM_WR  = 11'b000_0010_0000;
    localparam logic [10:0] S_REG_WE  = 11'b000_0001_0000;
    localparam logic [10:0] S_ALU_LD  = 11'b000_0000_1000;
    localparam logic [10:0] S_FLG_LD  = 11'b000_0000_0100;
    localparam logic [10:0] S_FLG_RST = 11'b000_0000_0010;
    localparam logic [10:0] S_OUT_LD  = 11'b000_0000_0001;

    logic   Clk;
    logic   rst;
    instr_t ir;
    flags_t flags;
    ctrl_t  ctrl;
    logic   halted;

    instr_t pending_instr;  // Word the IR takes on its next load
    instr_t ir_next;
    logic   load_req;       // ir_ld seen in this cycle
    int     cycles;
    int     errors;
    int     checks;
    int     tests;

    seq_ctrl_top UUT (
        .Clk    (Clk),
        .rst    (rst),
        .ir     (ir),
        .flags  (flags),
        .ctrl   (ctrl),
        .halted (halted)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // ------------------------------
    // IR model and timeout
    // ------------------------------
    always @(negedge Clk) begin
        load_req <= ctrl.ir_ld;
    end

    always @(posedge Clk) begin
        if (load_req) begin
            ir_next = pending_instr;    // Sampled on the load edge
            #1 ir = ir_next;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge Clk);
            cycles++;
        end
        $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    // Expected control word from strobes and selects
    function automatic ctrl_t word(input logic [10:0] s, input logic [1:0] pc,
                                   input logic [1:0] addr, input logic [1:0] data,
                                   input logic s1, input logic [1:0] outs,
                                   input logic [3:0] aop);
        return {s, pc, addr, data, s1, outs, aop};
    endfunction

    function automatic instr_t make_instr(input opcode_t op, input logic [2:0] field,
                                          input logic ign);
        instr_t i;
        i              = instr_t'(16'($urandom));   // Random register fields
        i.opcode       = op;
        i.dest_or_cond = field;
        i.ignore_dest  = ign;
        return i;
    endfunction

    task automatic check_ctrl(input ctrl_t exp, input logic exp_halted, input string what);
        checks++;
        assert (ctrl === exp && halted === exp_halted) else begin
            errors++;
            $display("MISMATCH at %0t: %s, ctrl %h expected %h, halted %b expected %b",
                     $time, what, ctrl, exp, halted, exp_halted);
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        tests++;
        $display("%s: %0d errors", name, errors - e0);
    endtask

    task automatic reset_dut();
        @(posedge Clk);
        #1;
        rst           = 1'b1;
        pending_instr = '0;             // NOP until a test loads a word
        repeat (8) @(posedge Clk);
        #1 rst = 1'b0;
    endtask

    // First three cycles after rst falls
    task automatic check_reset_seq();
        @(negedge Clk);
        check_ctrl(word(S_PC_RST, '0, '0, '0, '0, '0, '0), 1'b0, "reset cycle");
        @(negedge Clk);
        check_ctrl(word(S_MEM_EN, '0, ADDR_PC, '0, '0, '0, '0), 1'b0, "fetch address");
        @(negedge Clk);
        check_ctrl(word(S_IR_LD | S_PC_INC, '0, '0, '0, '0, '0, '0), 1'b0, "fetch load");
    endtask

    // One instruction through decode, optional execute and the following cycle
    task automatic run_instr(input instr_t instr, input flags_t f, input ctrl_t exp_dec,
                             input ctrl_t exp_exe, input logic has_exe, input string name);
        int n;
        @(posedge Clk);
        #1 pending_instr = instr;
        do begin
            @(negedge Clk);             // Wait for the next fetch load
        end while (ctrl.ir_ld !== 1'b1);
        @(posedge Clk);
        #1 flags = f;                   // IR model drives ir at the same time
        @(negedge Clk);
        check_ctrl(exp_dec, 1'b0, {name, " decode"});
        if (has_exe) begin
            @(negedge Clk);
            check_ctrl(exp_exe, 1'b0, {name, " execute"});
        end
        if (instr.opcode == OP_HLT) begin
            for (n = 0; n < 20; n++) begin
                @(negedge Clk);
                check_ctrl('0, 1'b1, {name, " idle"});
            end
        end else begin
            @(negedge Clk);
            check_ctrl(word(S_MEM_EN, '0, ADDR_PC, '0, '0, '0, '0), 1'b0, {name, " next fetch"});
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_reset();
        int e0;
        e0 = errors;
        reset_dut();
        check_reset_seq();
        finish_test("reset", e0);
    endtask

    task automatic test_alu();
        opcode_t ops[5];
        alu_op_t aops[5];
        logic    keep;
        int      k;
        int      e0;
        e0   = errors;
        ops  = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
        aops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
        for (k = 0; k < 10; k++) begin
            keep = (k % 2 == 0);        // Odd passes drop the result
            run_instr(make_instr(ops[k / 2], 3'(k), !keep), flags_t'(4'(k)),
                      word(S_FLG_LD | (keep ? S_ALU_LD : '0), '0, '0, '0, '0, '0, aops[k / 2]),
                      word(S_REG_WE, '0, '0, DATA_ALU, '0, '0, aops[k / 2]), keep, "alu");
        end
        finish_test("alu", e0);
    endtask

    task automatic test_memory();
        int e0;
        e0 = errors;
        run_instr(make_instr(OP_LDI, 3'd1, 1'b0), '0,
                  word(S_REG_WE, '0, '0, DATA_IMM, '0, '0, '0), '0, 1'b0, "ldi");
        run_instr(make_instr(OP_LD, 3'd2, 1'b0), '0,
                  word(S_MEM_EN, '0, ADDR_IMM, '0, '0, '0, '0),
                  word(S_REG_WE, '0, '0, DATA_MEM, '0, '0, '0), 1'b1, "ld");
        run_instr(make_instr(OP_ST, 3'd3, 1'b0), '0,
                  word(S_MEM_EN | S_MEM_WR, '0, ADDR_IMM, '0, SRC1_DEST, '0, '0),
                  '0, 1'b0, "st");
        run_instr(make_instr(OP_STX, 3'd4, 1'b0), '0,
                  word(S_MEM_EN | S_MEM_WR, '0, ADDR_REG2, '0, '0, '0, '0), '0, 1'b0, "stx");
        // Top bit of the field picks the register file
        run_instr(make_instr(OP_OUT, 3'b100, 1'b0), '0,
                  word(S_OUT_LD, '0, '0, '0, '0, OUT_REG, '0), '0, 1'b0, "out reg");
        run_instr(make_instr(OP_OUT, 3'b011, 1'b0), '0,
                  word(S_MEM_EN, '0, ADDR_IMM, '0, '0, OUT_MEM, '0),
                  word(S_OUT_LD, '0, '0, '0, '0, OUT_MEM, '0), 1'b1, "out mem");
        finish_test("memory", e0);
    endtask

    task automatic test_branch();
        flags_t f;
        logic   taken;
        int     c;
        int     n;
        int     e0;
        e0 = errors;
        for (c = 0; c < 4; c++) begin
            for (n = 0; n < 40; n++) begin
                f = flags_t'(4'($urandom));
                case (c)
                    0:       taken = f.z;               // EQ
                    1:       taken = !f.z;              // NE
                    2:       taken = (f.n != f.v);      // LT
                    default: taken = f.c;               // CS
                endcase
                run_instr(make_instr(OP_BRD, {2'(c), 1'($urandom)}, 1'($urandom)), f,
                          word(S_FLG_RST | (taken ? S_PC_LD : '0), PC_BRANCH, '0, '0, '0, '0, '0),
                          '0, 1'b0, "brd");
            end
        end
        run_instr(make_instr(OP_JMP, 3'd5, 1'b0), flags_t'(4'($urandom)),
                  word(S_PC_LD, PC_REG, '0, '0, '0, '0, '0), '0, 1'b0, "jmp");
        finish_test("branch", e0);
    endtask

    task automatic test_halt();
        int e0;
        e0 = errors;
        run_instr(make_instr(OP_NOP, 3'd0, 1'b0), '0, '0, '0, 1'b0, "nop");
        run_instr(make_instr(opcode_t'(4'd14), 3'd7, 1'b1), '0, '0, '0, 1'b0, "code 14");
        run_instr(make_instr(opcode_t'(4'd15), 3'd7, 1'b1), '0, '0, '0, 1'b0, "code 15");
        run_instr(make_instr(OP_HLT, 3'd0, 1'b0), '0, '0, '0, 1'b0, "hlt");
        reset_dut();                    // Only way out of idle
        check_reset_seq();
        run_instr(make_instr(OP_NOP, 3'd0, 1'b0), '0, '0, '0, 1'b0, "nop after reset");
        finish_test("halt", e0);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rst           = 1'b1;
        ir            = '0;
        flags         = '0;
        pending_instr = '0;
        ir_next       = '0;
        load_req      = 1'b0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        void'($urandom(32'h61ab_ae84));
        test_reset();
        test_alu();
        test_memory();
        test_branch();
        test_halt();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
